// File: include/cordic_atan_table.svh
`ifndef CORDIC_ATAN_TABLE_SVH
`define CORDIC_ATAN_TABLE_SVH

// ======================================================================
// atan(2^-i) in Q2.62 for i = 0 .. 61
// ======================================================================

localparam int atan_table_size = 62;

// Series is summed with 124 fraction bits, rounded to 62 at the end
localparam int atan_work_frac = 124;

typedef cordic_pkg::fixed_t atan_table_t [atan_table_size];

// atan(t) = t - t^3/3 + t^5/5 - ... with t = 2^-index
function automatic cordic_pkg::fixed_t atan_pow2(input int index);
    logic [127:0] sum;
    logic [127:0] term;
    int power;
    sum = '0;
    for (int k = 0; k < 40; k++) begin
        power = index * (2 * k + 1);
        if (power <= atan_work_frac) begin
            term = (128'd1 << (atan_work_frac - power)) / 128'(2 * k + 1);
            // Alternating terms, sum stays positive
            sum = (k % 2 == 0) ? sum + term : sum - term;
        end
    end
    sum = (sum + (128'd1 << 61)) >> 62;
    // Series converges too slowly at t = 1, use pi/4
    if (index == 0) begin
        return cordic_pkg::fixed_pi_half >>> 1;
    end
    return cordic_pkg::fixed_t'(sum[63:0]);
endfunction

function automatic atan_table_t build_atan_table();
    atan_table_t entries;
    for (int i = 0; i < atan_table_size; i++) begin
        entries[i] = atan_pow2(i);
    end
    return entries;
endfunction

localparam atan_table_t atan_table = build_atan_table();

`endif

// File: rtl/cordic_pkg.sv
`default_nettype none

package cordic_pkg;

    // ======================================================================
    // Widths and scalar types
    // ======================================================================

    // FP80 field widths
    typedef logic [14:0] fp80_exp_t;
    typedef logic [63:0] fp80_mant_t;

    // Q2.62 signed fixed point, range [-2, 2)
    typedef logic signed [63:0] fixed_t;

    // Micro-rotation index
    typedef logic [5:0] iter_t;

    // Quarter turns taken off the angle, modulo 4
    typedef logic [1:0] quadrant_t;

    typedef enum logic {
        mode_rotation,
        mode_vectoring
    } cordic_mode_e;

    // Extended precision word, explicit integer bit in mantissa
    typedef struct packed {
        logic       sign;
        fp80_exp_t  exponent;
        fp80_mant_t mantissa;
    } fp80_t;

    localparam int fp80_bias = 16383;
    localparam int fixed_frac_bits = 62;

    // pi/2 and CORDIC gain K = 0.6072529350... in Q2.62
    localparam fixed_t fixed_pi_half = 64'sh6487_ED51_10B4_611A;
    localparam fixed_t fixed_gain = 64'sh26DD_3B6A_10D7_969A;

    // ======================================================================
    // Transfer structs
    // ======================================================================

    // Operand a is the angle or x, operand b is y
    typedef struct packed {
        cordic_mode_e mode;
        fp80_t        operand_a;
        fp80_t        operand_b;
    } cordic_request_t;

    typedef struct packed {
        cordic_mode_e mode;
        quadrant_t    quadrant;
        logic         error;
        fixed_t       x;
        fixed_t       y;
        fixed_t       z;
    } cordic_job_t;

    typedef struct packed {
        cordic_mode_e mode;
        quadrant_t    quadrant;
        logic         error;
        fixed_t       x;
        fixed_t       y;
        fixed_t       z;
    } cordic_raw_t;

    // Sin or atan in a, cos or magnitude in b
    typedef struct packed {
        fp80_t result_a;
        fp80_t result_b;
        logic  error;
    } cordic_result_t;

    // ======================================================================
    // Format conversion
    // ======================================================================

    // Q2.62 value is mantissa * 2^(exponent - bias - 1)
    function automatic fixed_t fp80_to_fixed(input fp80_t value, output logic out_of_range);
        logic [63:0] magnitude;
        int shift;
        out_of_range = 1'b0;
        magnitude = '0;
        shift = fp80_bias + 1 - int'(value.exponent);
        if (value.exponent == '1) begin
            // Infinity or NaN
            out_of_range = 1'b1;
        end else if (value.exponent != '0) begin
            if (shift <= 0) begin
                // Magnitude 2 or more
                out_of_range = 1'b1;
            end else if (shift < 64) begin
                magnitude = value.mantissa >> shift;
            end
        end
        // Zero and denormals fall through as 0
        return value.sign ? -fixed_t'(magnitude) : fixed_t'(magnitude);
    endfunction

    // Normalize on the leading one, low bits truncated
    function automatic fp80_t fixed_to_fp80(input fixed_t value);
        fp80_t result;
        logic [63:0] magnitude;
        int lead;
        result = '0;
        magnitude = value[63] ? 64'(-value) : 64'(value);
        lead = -1;
        for (int i = 0; i < 64; i++) begin
            if (magnitude[i]) begin
                lead = i;
            end
        end
        if (lead >= 0) begin
            result.sign = value[63];
            result.exponent = fp80_exp_t'(fp80_bias - fixed_frac_bits + lead);
            result.mantissa = magnitude << (63 - lead);
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: rtl/cordic_input_stage.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_input_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_req,
    output logic                        in_ack,
    input  cordic_pkg::cordic_request_t request,
    output logic                        job_valid,
    input  logic                        job_ready,
    output cordic_pkg::cordic_job_t     job
);

    typedef enum logic [1:0] {
        state_idle,
        state_offer,
        state_release
    } state_e;

    // Folding limit for rotation angles
    localparam cordic_pkg::fixed_t pi_quarter = cordic_pkg::fixed_pi_half >>> 1;

    state_e state;

    cordic_pkg::fixed_t value_a;
    cordic_pkg::fixed_t value_b;
    logic a_bad;
    logic b_bad;
    cordic_pkg::cordic_job_t next_job;

    // ======================================================================
    // Operand conversion and angle folding
    // ======================================================================

    always_comb begin
        value_a = cordic_pkg::fp80_to_fixed(request.operand_a, a_bad);
        value_b = cordic_pkg::fp80_to_fixed(request.operand_b, b_bad);
        next_job = '0;
        next_job.mode = request.mode;
        if (request.mode == cordic_pkg::mode_rotation) begin
            if (a_bad) begin
                next_job.error = 1'b1;
            end else begin
                // Start from (K, 0) so the gain cancels
                next_job.x = cordic_pkg::fixed_gain;
                // One quarter turn at most, |angle| < 2
                if (value_a > pi_quarter) begin
                    next_job.z = value_a - cordic_pkg::fixed_pi_half;
                    next_job.quadrant = 2'd1;
                end else if (value_a < -pi_quarter) begin
                    next_job.z = value_a + cordic_pkg::fixed_pi_half;
                    next_job.quadrant = 2'd3;
                end else begin
                    next_job.z = value_a;
                end
            end
        end else begin
            // Vectoring needs x > 0 to converge
            if (a_bad || b_bad || value_a <= 0) begin
                next_job.error = 1'b1;
            end else begin
                next_job.x = value_a;
                next_job.y = value_b;
            end
        end
    end

    // ======================================================================
    // Handshake control
    // ======================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle: if (in_req) state <= state_offer;
                state_offer: if (job_ready) state <= state_release;
                state_release: if (!in_req) state <= state_idle;
                default: state <= state_idle;
            endcase
        end
    end

    // Converted job captured with the request
    always_ff @(posedge clk) begin
        if (state == state_idle && in_req) begin
            job <= next_job;
        end
    end

    assign job_valid = (state == state_offer);
    assign in_ack = (state == state_release);

endmodule

`default_nettype wire

// File: rtl/cordic_job_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_job_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    job_valid,
    output logic                    job_ready,
    input  cordic_pkg::cordic_job_t job,
    output logic                    out_valid,
    input  logic                    out_ready,
    output cordic_pkg::cordic_job_t out_job
);

    localparam int addr_width = $clog2(fifo_depth);
    localparam logic [addr_width:0] full_count = (addr_width + 1)'(fifo_depth);

    cordic_pkg::cordic_job_t mem [fifo_depth];
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width:0] count;
    logic do_write;
    logic do_read;

    // Head entry shows directly at the output
    assign out_valid = (count != '0);
    assign out_job = mem[rd_ptr];
    // Full FIFO still takes a write when the head leaves
    assign job_ready = (count != full_count) || out_ready;
    assign do_write = job_valid && job_ready;
    assign do_read = out_valid && out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) wr_ptr <= wr_ptr + 1'b1;
            if (do_read) rd_ptr <= rd_ptr + 1'b1;
            // Occupancy
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr] <= job;
    end

endmodule

`default_nettype wire

// File: rtl/cordic_iteration_engine.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_iteration_engine #(
    parameter int num_iterations = 48
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    job_valid,
    output logic                    job_ready,
    input  cordic_pkg::cordic_job_t job,
    output logic                    raw_valid,
    input  logic                    raw_ready,
    output cordic_pkg::cordic_raw_t raw
);

    `include "cordic_atan_table.svh"

    typedef enum logic [1:0] {
        state_idle,
        state_iterate,
        state_hold
    } state_e;

    localparam cordic_pkg::iter_t last_iter = cordic_pkg::iter_t'(num_iterations - 1);

    state_e state;
    cordic_pkg::iter_t iter;

    // Working job
    cordic_pkg::cordic_mode_e mode;
    cordic_pkg::quadrant_t quadrant;
    logic error;
    cordic_pkg::fixed_t x;
    cordic_pkg::fixed_t y;
    cordic_pkg::fixed_t z;

    cordic_pkg::fixed_t x_shift;
    cordic_pkg::fixed_t y_shift;
    cordic_pkg::fixed_t angle_step;
    logic rotate_up;

    // ======================================================================
    // One micro-rotation per cycle
    // ======================================================================

    always_comb begin
        x_shift = x >>> iter;
        y_shift = y >>> iter;
        angle_step = atan_table[iter];
        // Rotation drives z to 0, vectoring drives y to 0
        if (mode == cordic_pkg::mode_rotation) rotate_up = !z[63];
        else rotate_up = y[63];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= state_idle;
            iter <= '0;
        end else begin
            case (state)
                state_idle: begin
                    iter <= '0;
                    if (job_valid) state <= state_iterate;
                end
                state_iterate: begin
                    if (iter == last_iter) state <= state_hold;
                    else iter <= iter + 1'b1;
                end
                // Error jobs also wait here, keeping order
                state_hold: if (raw_ready) state <= state_idle;
                default: state <= state_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_idle && job_valid) begin
            mode <= job.mode;
            quadrant <= job.quadrant;
            error <= job.error;
            x <= job.x;
            y <= job.y;
            z <= job.z;
        end else if (state == state_iterate) begin
            x <= rotate_up ? x - y_shift : x + y_shift;
            y <= rotate_up ? y + x_shift : y - x_shift;
            z <= rotate_up ? z - angle_step : z + angle_step;
        end
    end

    assign job_ready = (state == state_idle);
    assign raw_valid = (state == state_hold);
    assign raw = '{mode: mode, quadrant: quadrant, error: error, x: x, y: y, z: z};

endmodule

`default_nettype wire

// File: rtl/cordic_result_formatter.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_result_formatter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       raw_valid,
    output logic                       raw_ready,
    input  cordic_pkg::cordic_raw_t    raw,
    output logic                       out_req,
    input  logic                       out_ack,
    output cordic_pkg::cordic_result_t result
);

    typedef enum logic [1:0] {
        state_idle,
        state_offer,
        state_release
    } state_e;

    state_e state;
    cordic_pkg::fixed_t value_a;
    cordic_pkg::fixed_t value_b;
    cordic_pkg::cordic_result_t next_result;

    // ======================================================================
    // Quadrant correction and FP80 packing
    // ======================================================================

    always_comb begin
        value_a = raw.z;
        value_b = raw.x;
        if (raw.mode == cordic_pkg::mode_rotation) begin
            // Undo the quarter turns taken at the input
            case (raw.quadrant)
                2'd0: begin value_a = raw.y;  value_b = raw.x;  end
                2'd1: begin value_a = raw.x;  value_b = -raw.y; end
                2'd2: begin value_a = -raw.y; value_b = -raw.x; end
                default: begin value_a = -raw.x; value_b = raw.y; end
            endcase
        end
        next_result.result_a = cordic_pkg::fixed_to_fp80(value_a);
        next_result.result_b = cordic_pkg::fixed_to_fp80(value_b);
        next_result.error = 1'b0;
        if (raw.error) next_result = '{result_a: '0, result_b: '0, error: 1'b1};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle: if (raw_valid) state <= state_offer;
                state_offer: if (out_ack) state <= state_release;
                state_release: if (!out_ack) state <= state_idle;
                default: state <= state_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_idle && raw_valid) result <= next_result;
    end

    assign raw_ready = (state == state_idle);
    assign out_req = (state == state_offer);

endmodule

`default_nettype wire

// File: rtl/cordic_unit.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_unit #(
    parameter int num_iterations = 48,
    parameter int fifo_depth = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    // Request port, four-phase
    input  logic                        in_req,
    output logic                        in_ack,
    input  cordic_pkg::cordic_request_t request,
    // Result port, four-phase
    output logic                        out_req,
    input  logic                        out_ack,
    output cordic_pkg::cordic_result_t  result
);

    // Input stage to FIFO
    logic job_valid;
    logic job_ready;
    cordic_pkg::cordic_job_t job;

    // FIFO to engine
    logic fifo_valid;
    logic fifo_ready;
    cordic_pkg::cordic_job_t fifo_job;

    // Engine to formatter
    logic raw_valid;
    logic raw_ready;
    cordic_pkg::cordic_raw_t raw;

    // ======================================================================
    // Producer, buffer, iteration, output
    // ======================================================================

    cordic_input_stage u_input_stage (
        .clk(clk), .reset(reset), .in_req(in_req), .in_ack(in_ack), .request(request),
        .job_valid(job_valid), .job_ready(job_ready), .job(job)
    );

    cordic_job_fifo #(.fifo_depth(fifo_depth)) u_job_fifo (
        .clk(clk), .reset(reset), .job_valid(job_valid), .job_ready(job_ready), .job(job),
        .out_valid(fifo_valid), .out_ready(fifo_ready), .out_job(fifo_job)
    );

    cordic_iteration_engine #(.num_iterations(num_iterations)) u_iteration_engine (
        .clk(clk), .reset(reset), .job_valid(fifo_valid), .job_ready(fifo_ready),
        .job(fifo_job), .raw_valid(raw_valid), .raw_ready(raw_ready), .raw(raw)
    );

    cordic_result_formatter u_result_formatter (
        .clk(clk), .reset(reset), .raw_valid(raw_valid), .raw_ready(raw_ready), .raw(raw),
        .out_req(out_req), .out_ack(out_ack), .result(result)
    );

endmodule

`default_nettype wire

// File: verification/cordic_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cordic_unit_tb;

    localparam int num_iterations = 48;
    localparam int wait_limit = 3000;
    localparam real pi = 3.14159265358979323846;
    localparam real tol_angle = 2.0 ** (-40);
    localparam real tol_magnitude = 2.0 ** (-38);

    logic clk;
    logic reset;
    logic in_req;
    logic in_ack;
    cordic_pkg::cordic_request_t request;
    logic out_req;
    logic out_ack;
    cordic_pkg::cordic_result_t result;

    // Pending requests and their expected results, in order
    cordic_pkg::cordic_request_t req_q[$];
    real exp_a_q[$];
    real exp_b_q[$];
    real tol_a_q[$];
    real tol_b_q[$];
    bit exp_err_q[$];

    bit [31:0] rand_state = 32'hdae02987;
    int error_count = 0;
    int pass_count = 0;
    int fail_count = 0;
    int errors_before;

    // Protocol monitor history
    logic prev_in_ack;
    logic prev_in_req;
    logic prev_out_req;
    cordic_pkg::cordic_result_t prev_result;

    cordic_unit UUT (
        .clk(clk), .reset(reset), .in_req(in_req), .in_ack(in_ack), .request(request),
        .out_req(out_req), .out_ack(out_ack), .result(result)
    );

    always #5 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic bit [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Uniform in [0, 1)
    function automatic real rand_unit();
        real value;
        value = next_rand();
        return value / (2.0 ** 32);
    endfunction

    function automatic real abs_real(input real value);
        return (value < 0.0) ? -value : value;
    endfunction

    // K as the product of 1/sqrt(1 + 2^-2i) over all iterations
    function automatic real cordic_gain();
        real k;
        k = 1.0;
        for (int i = 0; i < num_iterations; i++) begin
            k = k / $sqrt(1.0 + 2.0 ** (-2 * i));
        end
        return k;
    endfunction

    // Value is mantissa * 2^(exponent - 16383 - 63)
    function automatic real fp80_to_real(input cordic_pkg::fp80_t word);
        real mag;
        int exponent;
        mag = 0.0;
        exponent = word.exponent;
        if (exponent != 0) begin
            mag = word.mantissa;
            mag = mag * (2.0 ** (exponent - 16446));
        end
        return word.sign ? -mag : mag;
    endfunction

    function automatic cordic_pkg::fp80_t real_to_fp80(input real value);
        cordic_pkg::fp80_t word;
        real mag;
        int exp_unbiased;
        longint frac;
        word = '0;
        if (value != 0.0) begin
            mag = abs_real(value);
            exp_unbiased = 0;
            // Normalize into [1, 2)
            while (mag >= 2.0) begin
                mag = mag / 2.0;
                exp_unbiased++;
            end
            while (mag < 1.0) begin
                mag = mag * 2.0;
                exp_unbiased--;
            end
            frac = (mag - 1.0) * (2.0 ** 63);
            word.sign = (value < 0.0);
            word.exponent = 15'(16383 + exp_unbiased);
            word.mantissa = {1'b1, frac[62:0]};
        end
        return word;
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout: %s did not change within %0d cycles", what, wait_limit);
        $display("sim failed");
        $finish;
    endtask

    task automatic wait_in_ack(input logic level);
        int cycles;
        cycles = 0;
        while (in_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) abort_on_timeout("in_ack");
        end
    endtask

    task automatic wait_out_req(input logic level);
        int cycles;
        cycles = 0;
        while (out_req !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) abort_on_timeout("out_req");
        end
    endtask

    // ======================================================================
    // Stimulus and expected results
    // ======================================================================

    task automatic push_expected(input real a, input real b, input real ta, input real tb,
                                 input bit err);
        exp_a_q.push_back(a);
        exp_b_q.push_back(b);
        tol_a_q.push_back(ta);
        tol_b_q.push_back(tb);
        exp_err_q.push_back(err);
    endtask

    task automatic push_rotation(input real angle);
        cordic_pkg::cordic_request_t r;
        r = '0;
        r.mode = cordic_pkg::mode_rotation;
        r.operand_a = real_to_fp80(angle);
        req_q.push_back(r);
        push_expected($sin(angle), $cos(angle), tol_angle, tol_angle, 1'b0);
    endtask

    task automatic push_vectoring(input real x, input real y);
        cordic_pkg::cordic_request_t r;
        r.mode = cordic_pkg::mode_vectoring;
        r.operand_a = real_to_fp80(x);
        r.operand_b = real_to_fp80(y);
        req_q.push_back(r);
        // Magnitude keeps the CORDIC growth 1/K
        push_expected($atan(y / x), $sqrt(x * x + y * y) / cordic_gain(),
                      tol_angle, tol_magnitude, 1'b0);
    endtask

    task automatic push_error(input cordic_pkg::cordic_request_t r);
        req_q.push_back(r);
        push_expected(0.0, 0.0, 0.0, 0.0, 1'b1);
    endtask

    // Four-phase request, data held while in_req is high
    task automatic send_request(input cordic_pkg::cordic_request_t r);
        @(negedge clk);
        request = r;
        in_req = 1'b1;
        wait_in_ack(1'b1);
        in_req = 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic send_all();
        cordic_pkg::cordic_request_t r;
        while (req_q.size() > 0) begin
            r = req_q.pop_front();
            send_request(r);
        end
    endtask

    // Takes every expected result in order, ack delayed by 0 .. max_delay cycles
    task automatic receive_all(input int max_delay);
        real got_a;
        real got_b;
        real want_a;
        real want_b;
        real tol_a;
        real tol_b;
        bit want_err;
        int delay;
        while (exp_err_q.size() > 0) begin
            wait_out_req(1'b1);
            want_a = exp_a_q.pop_front();
            want_b = exp_b_q.pop_front();
            tol_a = tol_a_q.pop_front();
            tol_b = tol_b_q.pop_front();
            want_err = exp_err_q.pop_front();
            got_a = fp80_to_real(result.result_a);
            got_b = fp80_to_real(result.result_b);
            if (want_err) begin
                assert (result.error && result.result_a == '0 && result.result_b == '0)
                else begin
                    $display("[ERROR] %0t: expected error result, got error=%0b a=%h b=%h",
                             $time, result.error, result.result_a, result.result_b);
                    error_count++;
                end
            end else begin
                assert (!result.error) else begin
                    $display("[ERROR] %0t: error bit set on a legal request", $time);
                    error_count++;
                end
                assert (abs_real(got_a - want_a) <= tol_a) else begin
                    $display("[ERROR] %0t: result_a %.15e expected %.15e", $time, got_a, want_a);
                    error_count++;
                end
                assert (abs_real(got_b - want_b) <= tol_b) else begin
                    $display("[ERROR] %0t: result_b %.15e expected %.15e", $time, got_b, want_b);
                    error_count++;
                end
            end
            delay = (max_delay > 0) ? int'(next_rand() % (max_delay + 1)) : 0;
            repeat (delay) @(negedge clk);
            out_ack = 1'b1;
            wait_out_req(1'b0);
            out_ack = 1'b0;
        end
    endtask

    // No extra result may follow the last expected one
    task automatic check_quiet();
        repeat (num_iterations + 50) begin
            @(negedge clk);
            assert (!out_req) else begin
                $display("[ERROR] %0t: unexpected extra result", $time);
                error_count++;
            end
        end
    endtask

    task automatic run_batch(input int max_delay);
        fork
            send_all();
            receive_all(max_delay);
        join
        check_quiet();
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_before) begin
            pass_count++;
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
            $display("[FAIL] %s with %0d errors", name, error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // ======================================================================
    // Protocol monitor
    // ======================================================================

    always @(posedge clk) begin
        if (!reset) begin
            // in_ack rose on the previous edge, in_req had to be high there
            assert (!(in_ack && !prev_in_ack) || prev_in_req) else begin
                $display("[ERROR] %0t: in_ack rose without in_req", $time);
                error_count++;
            end
            assert (!(out_req && prev_out_req) || result == prev_result) else begin
                $display("[ERROR] %0t: result changed while out_req high", $time);
                error_count++;
            end
        end
        prev_in_ack <= in_ack;
        prev_in_req <= in_req;
        prev_out_req <= out_req;
        prev_result <= result;
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        cordic_pkg::cordic_request_t r;
        clk = 1'b0;
        reset = 1'b1;
        in_req = 1'b0;
        out_ack = 1'b0;
        request = '0;
        errors_before = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Idle outputs before the first request
        repeat (5) begin
            @(negedge clk);
            assert (!in_ack && !out_req) else begin
                $display("[ERROR] %0t: in_ack or out_req high after reset", $time);
                error_count++;
            end
        end
        report_test("reset");

        push_rotation(0.0);
        push_rotation(pi / 6.0);
        push_rotation(-pi / 6.0);
        push_rotation(pi / 4.0);
        push_rotation(-pi / 4.0);
        push_rotation(pi / 3.0);
        push_rotation(-pi / 3.0);
        push_rotation(pi / 2.0);
        push_rotation(-pi / 2.0);
        repeat (20) push_rotation((rand_unit() * 2.0 - 1.0) * 1.999);
        run_batch(0);
        report_test("rotation");

        repeat (20) push_vectoring(0.7 * (1.0 - rand_unit()), 1.4 * rand_unit() - 0.7);
        run_batch(0);
        report_test("vectoring");

        // Angle too large, infinity, NaN, x <= 0
        r = '0;
        r.mode = cordic_pkg::mode_rotation;
        r.operand_a = real_to_fp80(2.0);
        push_error(r);
        r.operand_a = real_to_fp80(-3.0);
        push_error(r);
        r.operand_a = {1'b0, 15'h7fff, 64'h8000_0000_0000_0000};
        push_error(r);
        r.mode = cordic_pkg::mode_vectoring;
        r.operand_a = real_to_fp80(0.5);
        r.operand_b = {1'b1, 15'h7fff, 64'hc000_0000_0000_0000};
        push_error(r);
        r.operand_a = '0;
        r.operand_b = real_to_fp80(0.25);
        push_error(r);
        r.operand_a = real_to_fp80(-0.5);
        push_error(r);
        run_batch(0);
        report_test("errors");

        // Burst deeper than the FIFO with slow acks
        repeat (12) begin
            case (next_rand() % 3)
                0: push_rotation((rand_unit() * 2.0 - 1.0) * 1.999);
                1: push_vectoring(0.7 * (1.0 - rand_unit()), 1.4 * rand_unit() - 0.7);
                default: begin
                    r = '0;
                    r.mode = cordic_pkg::mode_rotation;
                    r.operand_a = real_to_fp80(2.5);
                    push_error(r);
                end
            endcase
        end
        run_batch(60);
        report_test("backpressure");

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
rtl/cordic_pkg.sv
rtl/cordic_input_stage.sv
rtl/cordic_job_fifo.sv
rtl/cordic_iteration_engine.sv
rtl/cordic_result_formatter.sv
rtl/cordic_unit.sv
verification/cordic_unit_tb.sv

// File: Bender.yml
package:
  name: cordic_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/cordic_pkg.sv
      - rtl/cordic_input_stage.sv
      - rtl/cordic_job_fifo.sv
      - rtl/cordic_iteration_engine.sv
      - rtl/cordic_result_formatter.sv
      - rtl/cordic_unit.sv
  - target: test
    files:
      - verification/cordic_unit_tb.sv
